// ==== cls_pkg.sv ====
/*
 * shared definitions for the character LCD SPI driver
 * widths, escape code bytes, state and command enums, bus structs
 */
`default_nettype none

package cls_pkg;

    // ------------------------------------------------------------
    // widths and sizes
    // ------------------------------------------------------------

    // one display byte and one full display line
    localparam int c_byte_bits = 8;
    localparam int c_line_chars = 16;

    // the cursor escape is the longest sequence, the clear escape is shorter
    localparam int c_cmd_max_bytes = 7;
    localparam int c_clear_bytes = 4;

    // a frame byte count must reach 16 for a text line
    localparam int c_tx_len_bits = 5;

    // FIFO depth exceeds the longest frame so back-pressure stays rare
    localparam int c_fifo_depth = 32;
    localparam int c_fifo_ptr_bits = $clog2(c_fifo_depth);

    // boot wait, counted in clock-enable pulses
    localparam int c_boot_bits = 24;
    localparam logic [c_boot_bits-1:0] c_boot_ce_default = 24'd2000;

    // ------------------------------------------------------------
    // escape code bytes understood by the display controller
    // ------------------------------------------------------------
    localparam logic [c_byte_bits-1:0] c_ascii_esc = 8'h1B;
    localparam logic [c_byte_bits-1:0] c_ascii_bracket = 8'h5B;
    localparam logic [c_byte_bits-1:0] c_ascii_zero = 8'h30;
    localparam logic [c_byte_bits-1:0] c_ascii_semicolon = 8'h3B;
    localparam logic [c_byte_bits-1:0] c_ascii_clear_cmd = 8'h6A;
    localparam logic [c_byte_bits-1:0] c_ascii_cursor_cmd = 8'h48;

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------

    // element [c_line_chars-1] holds the first character of the line
    typedef logic [c_line_chars-1:0][c_byte_bits-1:0] cls_line_t;

    // command chosen in idle and built during the load state
    typedef enum logic [1:0] {
        cls_cmd_clear,
        cls_cmd_line1,
        cls_cmd_line2
    } cls_cmd_t;

    // sequencer states
    typedef enum logic [2:0] {
        st_boot,
        st_idle,
        st_load,
        st_cmd_run,
        st_cmd_wait,
        st_dat_run,
        st_dat_wait
    } cls_drv_state_t;

    // transmitter states
    typedef enum logic [1:0] {
        spi_idle,
        spi_load,
        spi_shift,
        spi_gap
    } spi_state_t;

    // go is a single enable-tick pulse on the last push of a frame
    typedef struct packed {
        logic go;
        logic [c_tx_len_bits-1:0] tx_len;
    } cls_tx_req_t;

    // SPI pins toward the display module
    typedef struct packed {
        logic sck;
        logic mosi;
        logic cs_n;
    } cls_spi_pins_t;

endpackage : cls_pkg

`default_nettype wire

// ==== cls_boot_timer.sv ====
/*
 * boot timer for the display controller
 * counts enable ticks after reset and then holds boot done high
 */
`timescale 1ns/1ps
`default_nettype none

module cls_boot_timer (
    input  wire logic                          i_ext_spi_clk_x,
    input  wire logic                          i_srst,
    input  wire logic                          i_spi_ce_4x,
    input  wire logic [cls_pkg::c_boot_bits-1:0] i_boot_ce_count,
    output logic                               o_boot_done
);

    import cls_pkg::*;

    // number of enable ticks seen since reset, saturates at count minus one
    logic [c_boot_bits-1:0] s_count;

    // done is raised one tick early so the sequencer leaves boot on tick N
    // and the ready flag is high exactly N ticks after reset
    assign o_boot_done = (s_count == (i_boot_ce_count - 1'b1));

    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            s_count <= '0;
        end else if (i_spi_ce_4x && !o_boot_done) begin
            // counting stops once done is reached, so done stays a level
            s_count <= s_count + 1'b1;
        end
    end

endmodule : cls_boot_timer

`default_nettype wire

// ==== cls_cmd_sequencer.sv ====
/*
 * command sequencer for the character LCD
 * accepts clear and line writes, builds escape and text bytes and pushes
 * them into the transmit FIFO with one start pulse per chip-select frame
 */
`timescale 1ns/1ps
`default_nettype none

module cls_cmd_sequencer (
    input  wire logic                          i_ext_spi_clk_x,
    input  wire logic                          i_srst,
    input  wire logic                          i_spi_ce_4x,
    input  wire logic                          i_boot_done,
    input  wire logic                          i_cmd_wr_clear_display,
    input  wire logic                          i_cmd_wr_text_line1,
    input  wire logic                          i_cmd_wr_text_line2,
    input  wire cls_pkg::cls_line_t            i_dat_ascii_line1,
    input  wire cls_pkg::cls_line_t            i_dat_ascii_line2,
    input  wire logic                          i_tx_ready,
    input  wire logic                          i_spi_idle,
    output logic                               o_push,
    output logic [cls_pkg::c_byte_bits-1:0]    o_push_byte,
    output cls_pkg::cls_tx_req_t               o_tx_req,
    output logic                               o_command_ready
);

    import cls_pkg::*;

    // ------------------------------------------------------------
    // state and buffers
    // ------------------------------------------------------------
    cls_drv_state_t s_state;
    cls_cmd_t s_cmd;

    // frame lengths of the escape frame and the text frame
    logic [c_tx_len_bits-1:0] s_cmd_len;
    logic [c_tx_len_bits-1:0] s_dat_len;

    // bytes still to push in the frame that is running
    logic [c_tx_len_bits-1:0] s_rem;

    // escape and text bytes, always pushed from the top element
    logic [c_cmd_max_bytes-1:0][c_byte_bits-1:0] s_esc_buf;
    cls_line_t s_txt_buf;

    // row digit of the cursor escape, '0' plus the row
    logic [c_byte_bits-1:0] s_row_digit;

    // ------------------------------------------------------------
    // outputs decoded from the registered state
    // ------------------------------------------------------------
    always_comb begin
        s_row_digit = (s_cmd == cls_cmd_line2) ? (c_ascii_zero + 8'd1) : c_ascii_zero;

        // a push needs an enable tick and room in the FIFO
        o_push = ((s_state == st_cmd_run) || (s_state == st_dat_run))
                 && i_spi_ce_4x && i_tx_ready;
        o_push_byte = (s_state == st_dat_run) ? s_txt_buf[c_line_chars-1]
                                              : s_esc_buf[c_cmd_max_bytes-1];

        // the start pulse rides on the last byte of the frame
        o_tx_req.go = o_push && (s_rem == 5'd1);
        o_tx_req.tx_len = (s_state == st_dat_run) ? s_dat_len : s_cmd_len;

        o_command_ready = (s_state == st_idle);
    end

    // ------------------------------------------------------------
    // control FSM
    // ------------------------------------------------------------
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            s_state <= st_boot;
            s_cmd <= cls_cmd_clear;
            s_cmd_len <= '0;
            s_dat_len <= '0;
            s_rem <= '0;
        end else if (i_spi_ce_4x) begin
            case (s_state)
                st_boot: begin
                    if (i_boot_done) begin
                        s_state <= st_idle;
                    end
                end

                st_idle: begin
                    // strobes are sampled only here, clear has priority
                    if (i_cmd_wr_clear_display) begin
                        s_cmd <= cls_cmd_clear;
                        s_state <= st_load;
                    end else if (i_cmd_wr_text_line1) begin
                        s_cmd <= cls_cmd_line1;
                        s_state <= st_load;
                    end else if (i_cmd_wr_text_line2) begin
                        s_cmd <= cls_cmd_line2;
                        s_state <= st_load;
                    end
                end

                st_load: begin
                    // a clear has no text frame behind its escape frame
                    if (s_cmd == cls_cmd_clear) begin
                        s_cmd_len <= c_tx_len_bits'(c_clear_bytes);
                        s_dat_len <= '0;
                        s_rem <= c_tx_len_bits'(c_clear_bytes);
                    end else begin
                        s_cmd_len <= c_tx_len_bits'(c_cmd_max_bytes);
                        s_dat_len <= c_tx_len_bits'(c_line_chars);
                        s_rem <= c_tx_len_bits'(c_cmd_max_bytes);
                    end
                    s_state <= st_cmd_run;
                end

                st_cmd_run: begin
                    // without room the byte is held until the FIFO drains
                    if (i_tx_ready) begin
                        s_rem <= s_rem - 1'b1;
                        if (s_rem == 5'd1) begin
                            s_state <= st_cmd_wait;
                        end
                    end
                end

                st_cmd_wait: begin
                    if (i_spi_idle) begin
                        if (s_dat_len != '0) begin
                            s_rem <= s_dat_len;
                            s_state <= st_dat_run;
                        end else begin
                            s_state <= st_idle;
                        end
                    end
                end

                st_dat_run: begin
                    if (i_tx_ready) begin
                        s_rem <= s_rem - 1'b1;
                        if (s_rem == 5'd1) begin
                            s_state <= st_dat_wait;
                        end
                    end
                end

                st_dat_wait: begin
                    if (i_spi_idle) begin
                        s_state <= st_idle;
                    end
                end

                default: begin
                    s_state <= st_boot;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // escape and text buffers
    // ------------------------------------------------------------
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_spi_ce_4x) begin
            if (s_state == st_load) begin
                // the clear escape sits in the top four elements
                if (s_cmd == cls_cmd_clear) begin
                    s_esc_buf <= {c_ascii_esc, c_ascii_bracket, c_ascii_zero,
                                  c_ascii_clear_cmd, 24'h000000};
                end else begin
                    s_esc_buf <= {c_ascii_esc, c_ascii_bracket, s_row_digit,
                                  c_ascii_semicolon, c_ascii_zero, c_ascii_zero,
                                  c_ascii_cursor_cmd};
                end
                s_txt_buf <= (s_cmd == cls_cmd_line2) ? i_dat_ascii_line2 : i_dat_ascii_line1;
            end else if (o_push) begin
                // move the next byte up to the top element
                if (s_state == st_dat_run) begin
                    s_txt_buf <= {s_txt_buf[c_line_chars-2:0], 8'h00};
                end else begin
                    s_esc_buf <= {s_esc_buf[c_cmd_max_bytes-2:0], 8'h00};
                end
            end
        end
    end

endmodule : cls_cmd_sequencer

`default_nettype wire

// ==== cls_tx_fifo.sv ====
/*
 * transmit byte FIFO between the sequencer and the SPI transmitter
 * circular buffer with first-word-fall-through read data
 */
`timescale 1ns/1ps
`default_nettype none

module cls_tx_fifo (
    input  wire logic                          i_ext_spi_clk_x,
    input  wire logic                          i_srst,
    input  wire logic                          i_push,
    input  wire logic [cls_pkg::c_byte_bits-1:0] i_push_byte,
    input  wire logic                          i_pop,
    output logic [cls_pkg::c_byte_bits-1:0]    o_pop_byte,
    output logic                               o_empty,
    output logic                               o_tx_ready
);

    import cls_pkg::*;

    logic [c_byte_bits-1:0] s_mem [c_fifo_depth];
    logic [c_fifo_ptr_bits-1:0] s_wr_ptr;
    logic [c_fifo_ptr_bits-1:0] s_rd_ptr;

    // one extra bit so a full buffer can be told apart from an empty one
    logic [c_fifo_ptr_bits:0] s_count;

    logic s_do_push;
    logic s_do_pop;

    assign o_empty = (s_count == '0);
    assign o_tx_ready = (s_count != (c_fifo_ptr_bits + 1)'(c_fifo_depth));

    // the head entry is always visible on the read port
    assign o_pop_byte = s_mem[s_rd_ptr];

    // strobes against a full or empty buffer are dropped
    assign s_do_push = i_push && o_tx_ready;
    assign s_do_pop = i_pop && !o_empty;

    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            s_wr_ptr <= '0;
            s_rd_ptr <= '0;
            s_count <= '0;
        end else begin
            if (s_do_push) begin
                s_wr_ptr <= s_wr_ptr + 1'b1;
            end
            if (s_do_pop) begin
                s_rd_ptr <= s_rd_ptr + 1'b1;
            end
            // simultaneous push and pop keep the count
            if (s_do_push && !s_do_pop) begin
                s_count <= s_count + 1'b1;
            end else if (s_do_pop && !s_do_push) begin
                s_count <= s_count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_ext_spi_clk_x) begin
        if (s_do_push) begin
            s_mem[s_wr_ptr] <= i_push_byte;
        end
    end

endmodule : cls_tx_fifo

`default_nettype wire

// ==== cls_spi_tx.sv ====
/*
 * SPI mode 0 transmitter
 * sends one frame of a given byte count under chip select, MSB first,
 * with SCK at a quarter of the enable rate
 */
`timescale 1ns/1ps
`default_nettype none

module cls_spi_tx (
    input  wire logic                          i_ext_spi_clk_x,
    input  wire logic                          i_srst,
    input  wire logic                          i_spi_ce_4x,
    input  wire cls_pkg::cls_tx_req_t          i_tx_req,
    input  wire logic [cls_pkg::c_byte_bits-1:0] i_fifo_byte,
    input  wire logic                          i_fifo_empty,
    output logic                               o_pop,
    output logic                               o_spi_idle,
    output cls_pkg::cls_spi_pins_t             o_pins
);

    import cls_pkg::*;

    spi_state_t s_state;

    // four enable ticks per bit, SCK is high in phases 2 and 3
    logic [1:0] s_phase;
    logic [$clog2(c_byte_bits)-1:0] s_bit;

    // bytes of the frame not yet popped
    logic [c_tx_len_bits-1:0] s_left;
    logic [c_byte_bits-1:0] s_shift;

    logic s_bit_end;
    logic s_more;

    // ------------------------------------------------------------
    // decode
    // ------------------------------------------------------------
    always_comb begin
        s_bit_end = (s_phase == 2'd3);

        // another byte starts only if the count allows and the FIFO has one
        s_more = (s_left != '0) && !i_fifo_empty;

        // pop on the first byte and again at the end of each last bit, so
        // consecutive bytes follow without a gap
        o_pop = i_spi_ce_4x && s_more
                && ((s_state == spi_load)
                    || ((s_state == spi_shift) && s_bit_end && (s_bit == '0)));

        o_spi_idle = (s_state == spi_idle);
        o_pins.cs_n = !((s_state == spi_load) || (s_state == spi_shift));
        o_pins.sck = (s_state == spi_shift) && s_phase[1];
        o_pins.mosi = s_shift[c_byte_bits-1];
    end

    // ------------------------------------------------------------
    // frame FSM
    // ------------------------------------------------------------
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            s_state <= spi_idle;
            s_phase <= '0;
            s_bit <= '0;
            s_left <= '0;
        end else if (i_spi_ce_4x) begin
            case (s_state)
                spi_idle: begin
                    if (i_tx_req.go) begin
                        s_left <= i_tx_req.tx_len;
                        s_state <= spi_load;
                    end
                end

                spi_load: begin
                    // chip select is already low here with SCK still low
                    s_phase <= '0;
                    if (s_more) begin
                        s_left <= s_left - 1'b1;
                        s_bit <= 3'(c_byte_bits - 1);
                        s_state <= spi_shift;
                    end else begin
                        s_state <= spi_gap;
                    end
                end

                spi_shift: begin
                    s_phase <= s_phase + 1'b1;
                    if (s_bit_end) begin
                        if (s_bit != '0) begin
                            s_bit <= s_bit - 1'b1;
                        end else if (s_more) begin
                            s_left <= s_left - 1'b1;
                            s_bit <= 3'(c_byte_bits - 1);
                        end else begin
                            // an empty FIFO at a byte start also ends the frame
                            s_state <= spi_gap;
                        end
                    end
                end

                spi_gap: begin
                    // one SCK period with chip select high before idle
                    s_phase <= s_phase + 1'b1;
                    if (s_bit_end) begin
                        s_state <= spi_idle;
                    end
                end

                default: begin
                    s_state <= spi_idle;
                end
            endcase
        end
    end

    // MOSI moves as SCK falls, on the wrap from phase 3 to phase 0
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_spi_ce_4x) begin
            if (o_pop) begin
                s_shift <= i_fifo_byte;
            end else if ((s_state == spi_shift) && s_bit_end) begin
                s_shift <= {s_shift[c_byte_bits-2:0], 1'b0};
            end
        end
    end

endmodule : cls_spi_tx

`default_nettype wire

// ==== pmod_cls_spi_top.sv ====
/*
 * character LCD SPI driver top level
 * boot timer, command sequencer, byte FIFO and mode 0 transmitter
 */
`timescale 1ns/1ps
`default_nettype none

module pmod_cls_spi_top #(
    parameter logic [cls_pkg::c_boot_bits-1:0] p_boot_ce_count = cls_pkg::c_boot_ce_default
) (
    input  wire logic                  i_ext_spi_clk_x,
    input  wire logic                  i_srst,
    input  wire logic                  i_spi_ce_4x,
    input  wire logic                  i_cmd_wr_clear_display,
    input  wire logic                  i_cmd_wr_text_line1,
    input  wire logic                  i_cmd_wr_text_line2,
    input  wire cls_pkg::cls_line_t    i_dat_ascii_line1,
    input  wire cls_pkg::cls_line_t    i_dat_ascii_line2,
    output logic                       o_command_ready,
    output cls_pkg::cls_spi_pins_t     o_spi
);

    import cls_pkg::*;

    logic s_boot_done;
    logic s_push;
    logic [c_byte_bits-1:0] s_push_byte;
    logic s_pop;
    logic [c_byte_bits-1:0] s_pop_byte;
    logic s_empty;
    logic s_tx_ready;
    logic s_spi_idle;
    cls_tx_req_t s_tx_req;

    cls_boot_timer cls_boot_timer_inst (
        .i_ext_spi_clk_x (i_ext_spi_clk_x),
        .i_srst          (i_srst),
        .i_spi_ce_4x     (i_spi_ce_4x),
        .i_boot_ce_count (p_boot_ce_count),
        .o_boot_done     (s_boot_done)
    );

    cls_cmd_sequencer cls_cmd_sequencer_inst (
        .i_ext_spi_clk_x        (i_ext_spi_clk_x),
        .i_srst                 (i_srst),
        .i_spi_ce_4x            (i_spi_ce_4x),
        .i_boot_done            (s_boot_done),
        .i_cmd_wr_clear_display (i_cmd_wr_clear_display),
        .i_cmd_wr_text_line1    (i_cmd_wr_text_line1),
        .i_cmd_wr_text_line2    (i_cmd_wr_text_line2),
        .i_dat_ascii_line1      (i_dat_ascii_line1),
        .i_dat_ascii_line2      (i_dat_ascii_line2),
        .i_tx_ready             (s_tx_ready),
        .i_spi_idle             (s_spi_idle),
        .o_push                 (s_push),
        .o_push_byte            (s_push_byte),
        .o_tx_req               (s_tx_req),
        .o_command_ready        (o_command_ready)
    );

    cls_tx_fifo cls_tx_fifo_inst (
        .i_ext_spi_clk_x (i_ext_spi_clk_x),
        .i_srst          (i_srst),
        .i_push          (s_push),
        .i_push_byte     (s_push_byte),
        .i_pop           (s_pop),
        .o_pop_byte      (s_pop_byte),
        .o_empty         (s_empty),
        .o_tx_ready      (s_tx_ready)
    );

    cls_spi_tx cls_spi_tx_inst (
        .i_ext_spi_clk_x (i_ext_spi_clk_x),
        .i_srst          (i_srst),
        .i_spi_ce_4x     (i_spi_ce_4x),
        .i_tx_req        (s_tx_req),
        .i_fifo_byte     (s_pop_byte),
        .i_fifo_empty    (s_empty),
        .o_pop           (s_pop),
        .o_spi_idle      (s_spi_idle),
        .o_pins          (o_spi)
    );

endmodule : pmod_cls_spi_top

`default_nettype wire

// ==== tb_pmod_cls.sv ====
/*
 * testbench for the character LCD SPI driver
 * decodes SPI frames at the pins and checks boot, clear, line writes,
 * command priority and busy behavior against the escape byte rules
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pmod_cls;

    import cls_pkg::*;

    // ------------------------------------------------------------
    // run limits
    // ------------------------------------------------------------
    localparam int c_boot_ticks = 40;
    // 8 bits, 4 enable ticks per bit, 2 clocks per enable tick
    localparam int c_byte_clocks = 64;
    localparam int c_cmd_cycles = 23 * c_byte_clocks + 200;
    localparam int c_wd_cycles = 5 + 2 * c_boot_ticks + 10 * 23 * c_byte_clocks;

    logic ext_spi_clk_x;
    logic srst;
    logic spi_ce_4x;
    logic cmd_clear;
    logic cmd_line1;
    logic cmd_line2;
    cls_line_t line1;
    cls_line_t line2;
    logic command_ready;
    cls_spi_pins_t spi;

    integer seed = 32'h1fecd7eb;
    int checks = 0;
    int errors = 0;
    int ticks;
    int cycles;

    // decoded frames, bytes of all frames in one queue and one length per frame
    logic [7:0] rx_bytes[$];
    int rx_len[$];
    logic [7:0] exp_bytes[$];

    // frame decoder state
    logic prev_sck = 1'b0;
    logic prev_cs_n = 1'b1;
    logic [7:0] cur_byte = '0;
    int bit_cnt = 0;
    int frame_cnt = 0;

    pmod_cls_spi_top #(
        .p_boot_ce_count (24'(c_boot_ticks))
    ) pmod_cls_spi_top_inst (
        .i_ext_spi_clk_x        (ext_spi_clk_x),
        .i_srst                 (srst),
        .i_spi_ce_4x            (spi_ce_4x),
        .i_cmd_wr_clear_display (cmd_clear),
        .i_cmd_wr_text_line1    (cmd_line1),
        .i_cmd_wr_text_line2    (cmd_line2),
        .i_dat_ascii_line1      (line1),
        .i_dat_ascii_line2      (line2),
        .o_command_ready        (command_ready),
        .o_spi                  (spi)
    );

    initial ext_spi_clk_x = 1'b0;
    always #10 ext_spi_clk_x = !ext_spi_clk_x;

    // the enable runs at half the clock rate, also during reset
    always @(posedge ext_spi_clk_x) begin
        #1 spi_ce_4x = !spi_ce_4x;
    end

    // ------------------------------------------------------------
    // frame decoder, works on values sampled at the clock edge
    // ------------------------------------------------------------
    always @(posedge ext_spi_clk_x) begin
        if (!srst) begin
            if (spi.cs_n != prev_cs_n) begin
                // mode 0 keeps sck low around every chip select edge
                checks++;
                assert (spi.sck == 1'b0) else begin
                    errors++;
                    $display("sck was high while cs_n changed at %0t", $time);
                end
                if (!spi.cs_n) begin
                    bit_cnt = 0;
                    frame_cnt = 0;
                end else begin
                    checks++;
                    assert (bit_cnt == 0) else begin
                        errors++;
                        $display("frame ended after %0d stray sck rises", bit_cnt);
                    end
                    rx_len.push_back(frame_cnt);
                end
            end else if (!spi.cs_n && spi.sck && !prev_sck) begin
                cur_byte = {cur_byte[6:0], spi.mosi};
                bit_cnt++;
                if (bit_cnt == 8) begin
                    rx_bytes.push_back(cur_byte);
                    frame_cnt++;
                    bit_cnt = 0;
                end
            end
            if (!spi.cs_n) begin
                checks++;
                assert (!command_ready) else begin
                    errors++;
                    $display("command ready was high inside a frame at %0t", $time);
                end
            end
            prev_sck = spi.sck;
            prev_cs_n = spi.cs_n;
        end
    end

    // watchdog sized for boot plus ten worst-case commands
    initial begin
        repeat (c_wd_cycles) @(posedge ext_spi_clk_x);
        $display("watchdog expired after %0d cycles, the test did not finish", c_wd_cycles);
        $display("checks %0d, errors %0d", checks, errors);
        $display("Result: FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic drive_text();
        logic [31:0] rnd;
        @(posedge ext_spi_clk_x);
        #1;
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            line1[i] = rnd[7:0];
            rnd = $random(seed);
            line2[i] = rnd[7:0];
        end
    endtask

    // strobes are held two clocks so that exactly one enable tick sees them
    task automatic strobe_cmd(input logic clr, input logic l1, input logic l2);
        @(posedge ext_spi_clk_x);
        #1;
        cmd_clear = clr;
        cmd_line1 = l1;
        cmd_line2 = l2;
        repeat (2) @(posedge ext_spi_clk_x);
        #1;
        cmd_clear = 1'b0;
        cmd_line1 = 1'b0;
        cmd_line2 = 1'b0;
    endtask

    task automatic expect_accepted(input string name);
        checks++;
        assert (!command_ready) else begin
            errors++;
            $display("%s was not accepted, command ready stayed high", name);
        end
    endtask

    task automatic wait_ready(input string name);
        int n;
        n = 0;
        while (!command_ready && n < c_cmd_cycles) begin
            @(posedge ext_spi_clk_x);
            n++;
        end
        checks++;
        assert (command_ready) else begin
            errors++;
            $display("%s did not finish within %0d cycles", name, c_cmd_cycles);
        end
    endtask

    // clear escape is ESC [ 0 j
    task automatic build_clear();
        exp_bytes.delete();
        exp_bytes.push_back(8'h1B);
        exp_bytes.push_back(8'h5B);
        exp_bytes.push_back(8'h30);
        exp_bytes.push_back(8'h6A);
    endtask

    // cursor escape is ESC [ row ; 0 0 H, row digit counted from '0'
    task automatic build_cursor(input logic [7:0] row);
        exp_bytes.delete();
        exp_bytes.push_back(8'h1B);
        exp_bytes.push_back(8'h5B);
        exp_bytes.push_back(8'h30 + row);
        exp_bytes.push_back(8'h3B);
        exp_bytes.push_back(8'h30);
        exp_bytes.push_back(8'h30);
        exp_bytes.push_back(8'h48);
    endtask

    // the first character sits in the top byte of the line
    task automatic build_text(input cls_line_t line);
        exp_bytes.delete();
        for (int i = 0; i < 16; i++) begin
            exp_bytes.push_back(line[15-i]);
        end
    endtask

    task automatic check_frame(input string name);
        int n;
        logic [7:0] act;
        checks++;
        assert (rx_len.size() > 0) else begin
            errors++;
            $display("no frame was received for %s", name);
        end
        if (rx_len.size() > 0) begin
            n = rx_len.pop_front();
            checks++;
            assert (n == exp_bytes.size()) else begin
                errors++;
                $display("Mismatch %s length: expected %0d, actual %0d",
                         name, exp_bytes.size(), n);
            end
            for (int i = 0; i < n; i++) begin
                act = rx_bytes.pop_front();
                if (i < exp_bytes.size()) begin
                    checks++;
                    assert (act == exp_bytes[i]) else begin
                        errors++;
                        $display("Mismatch %s byte %0d: expected %h, actual %h",
                                 name, i, exp_bytes[i], act);
                    end
                end
            end
        end
    endtask

    task automatic check_no_frame(input string name);
        checks++;
        assert (rx_len.size() == 0) else begin
            errors++;
            $display("%0d extra frames after %s", rx_len.size(), name);
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        srst = 1'b1;
        spi_ce_4x = 1'b0;
        cmd_clear = 1'b0;
        cmd_line1 = 1'b0;
        cmd_line2 = 1'b0;
        line1 = '0;
        line2 = '0;
        repeat (5) @(posedge ext_spi_clk_x);
        #1 srst = 1'b0;

        checks++;
        assert (!command_ready && spi.cs_n && !spi.sck) else begin
            errors++;
            $display("outputs are not inactive after reset");
        end

        // count enable ticks until ready rises
        ticks = 0;
        cycles = 0;
        do begin
            @(posedge ext_spi_clk_x);
            cycles++;
            if (!command_ready && spi_ce_4x) begin
                ticks++;
            end
        end while (!command_ready && cycles < 4 * c_boot_ticks);
        checks++;
        assert (command_ready && ticks == c_boot_ticks) else begin
            errors++;
            $display("Mismatch boot ticks: expected %0d, actual %0d",
                     c_boot_ticks, ticks);
        end
        check_no_frame("boot");

        strobe_cmd(1'b1, 1'b0, 1'b0);
        expect_accepted("clear");
        wait_ready("clear");
        build_clear();
        check_frame("clear");
        check_no_frame("clear");

        drive_text();
        strobe_cmd(1'b0, 1'b1, 1'b0);
        expect_accepted("line1");
        wait_ready("line1");
        build_cursor(8'd0);
        check_frame("line1 cursor");
        build_text(line1);
        check_frame("line1 text");
        check_no_frame("line1");

        drive_text();
        strobe_cmd(1'b0, 1'b0, 1'b1);
        expect_accepted("line2");
        wait_ready("line2");
        build_cursor(8'd1);
        check_frame("line2 cursor");
        build_text(line2);
        check_frame("line2 text");
        check_no_frame("line2");

        // clear wins over both line writes
        drive_text();
        strobe_cmd(1'b1, 1'b1, 1'b1);
        expect_accepted("priority");
        wait_ready("priority");
        build_clear();
        check_frame("priority");
        check_no_frame("priority");

        // a second strobe during a running command is dropped
        drive_text();
        strobe_cmd(1'b0, 1'b1, 1'b0);
        expect_accepted("busy");
        repeat (20) @(posedge ext_spi_clk_x);
        strobe_cmd(1'b0, 1'b1, 1'b0);
        wait_ready("busy");
        build_cursor(8'd0);
        check_frame("busy cursor");
        build_text(line1);
        check_frame("busy text");
        // long enough for a whole extra command to show up as frames
        repeat (c_cmd_cycles) @(posedge ext_spi_clk_x);
        check_no_frame("busy");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_pmod_cls

`default_nettype wire

// ==== files.f ====
cls_pkg.sv
cls_boot_timer.sv
cls_cmd_sequencer.sv
cls_tx_fifo.sv
cls_spi_tx.sv
pmod_cls_spi_top.sv
tb_pmod_cls.sv
